/* hw/camera_cfg_pkg.sv */
// Camera config package with bus widths, register table constants and FSM state encodings
package camera_cfg_pkg;

   typedef logic [15:0] reg_addr_t;          // Sensor register address
   typedef logic [7:0]  reg_val_t;           // Register value
   typedef logic [23:0] reg_entry_t;         // {address, value}
   typedef logic [31:0] sccb_cmd_t;          // {device address, entry}
   typedef logic [4:0]  tbl_index_t;         // Table index, 20 entries

   localparam logic [7:0] SCCB_DEV_ADDR = 8'h78;     // Sensor write address

   localparam int INIT_COUNT = 18;                   // Setup plus strobe enable entries

   localparam tbl_index_t STROBE_ON_IDX  = 5'd18;    // Strobe request on
   localparam tbl_index_t STROBE_OFF_IDX = 5'd19;    // Strobe request off

   // Producer states
   typedef enum logic [1:0] {
      INIT_PUSH,                             // Walking the init table
      INIT_DRAIN,                            // Waiting for bus to finish
      READY,                                 // Idle, watching the key
      STROBE_PUSH                            // One strobe write pending
   } seq_state_t;

   // Bus writer states
   typedef enum logic [2:0] {
      IDLE,                                  // Bus released
      START,                                 // SDA low with SCL high
      BIT_LOW,                               // Data bit, SCL low phase
      BIT_HIGH,                              // Data bit, SCL high phase
      ACK_LOW,                               // SDA released, SCL low
      ACK_HIGH,                              // Slave ack sampled
      STOP                                   // SDA rises with SCL high
   } wr_state_t;

endpackage

/* hw/sensor_reg_table.sv */
// Sensor register table, maps a table index to its address and value entry
`timescale 1ns/1ps

module sensor_reg_table (
   input  camera_cfg_pkg::tbl_index_t index,
   output camera_cfg_pkg::reg_entry_t entry
);

   import camera_cfg_pkg::*;

   reg_addr_t addr;                          // Register address field
   reg_val_t  val;                           // Value field

   always_comb begin
      case (index)
         // System clock and reset
         5'd0:    {addr, val} = 24'h310311;  // Clock from pad
         5'd1:    {addr, val} = 24'h300882;  // Software reset
         5'd2:    {addr, val} = 24'h300842;  // Software power down
         5'd3:    {addr, val} = 24'h310303;  // Clock from PLL
         5'd4:    {addr, val} = 24'h3017ff;  // FREX, VSYNC, HREF, PCLK out
         5'd5:    {addr, val} = 24'h3018ff;  // Data and GPIO out
         5'd6:    {addr, val} = 24'h30341a;  // 10 bit mode
         5'd7:    {addr, val} = 24'h303713;  // PLL dividers
         5'd8:    {addr, val} = 24'h310801;  // PCLK and SCLK dividers
         // Analog setup
         5'd9:    {addr, val} = 24'h363036;
         5'd10:   {addr, val} = 24'h36310e;
         5'd11:   {addr, val} = 24'h3632e2;
         5'd12:   {addr, val} = 24'h363312;
         5'd13:   {addr, val} = 24'h3621e0;
         5'd14:   {addr, val} = 24'h3704a0;
         5'd15:   {addr, val} = 24'h37035a;
         // Strobe enable, part of init
         5'd16:   {addr, val} = 24'h301602;  // Strobe output enable
         5'd17:   {addr, val} = 24'h3b070a;  // FREX strobe mode 1
         // Key driven strobe requests
         5'd18:   {addr, val} = 24'h3b0083;  // Request on, LED3 mode
         5'd19:   {addr, val} = 24'h3b0000;  // Request off
         default: {addr, val} = 24'h000000;
      endcase
   end

   assign entry = {addr, val};               // Address first, as sent on the bus

endmodule

/* hw/key_debounce.sv */
// Key debouncer, pulses a press or release event once the key holds its new level
`timescale 1ns/1ps

module key_debounce #(
   parameter int DEBOUNCE_TICKS = 200
) (
   input  logic clock_20k,
   input  logic camera_rstn,
   input  logic key,                         // Low when pressed
   output logic press_evt,
   output logic release_evt
);

   localparam int CW = $clog2(DEBOUNCE_TICKS + 1);
   localparam logic [CW-1:0] CNT_MAX  = CW'(DEBOUNCE_TICKS);
   localparam logic [CW-1:0] CNT_FIRE = CW'(DEBOUNCE_TICKS - 1);

   logic [CW-1:0] low_cnt;                   // Cycles spent low
   logic [CW-1:0] high_cnt;                  // Cycles spent high

   always_ff @(posedge clock_20k or negedge camera_rstn) begin
      if (!camera_rstn) begin
         low_cnt     <= '0;
         high_cnt    <= '0;
         press_evt   <= 1'b0;
         release_evt <= 1'b0;
      end else begin
         if (key)
            low_cnt <= '0;                   // High level restarts press count
         else if (low_cnt < CNT_MAX)
            low_cnt <= low_cnt + 1'b1;       // Saturates, so one pulse per press

         if (!key)
            high_cnt <= '0;
         else if (high_cnt < CNT_MAX)
            high_cnt <= high_cnt + 1'b1;

         // Fires on the DEBOUNCE_TICKS-th sample at the new level
         press_evt   <= !key && (low_cnt == CNT_FIRE);
         release_evt <= key && (high_cnt == CNT_FIRE);
      end
   end

endmodule

/* hw/config_sequencer.sv */
// Config sequencer, pushes the init table into the command FIFO then strobe writes on key events
`timescale 1ns/1ps

module config_sequencer (
   input  logic                      clock_20k,
   input  logic                      camera_rstn,
   input  logic                      init_en,
   input  logic                      press_evt,
   input  logic                      release_evt,
   input  logic                      full,
   input  logic                      empty,
   input  logic                      busy,
   output logic                      push,
   output camera_cfg_pkg::sccb_cmd_t push_cmd,
   output logic                      config_done,
   output logic                      strobe_flash
);

   import camera_cfg_pkg::*;

   seq_state_t state;
   tbl_index_t idx;                          // Current table entry
   reg_entry_t entry;
   logic       push_req;                     // Command waiting for FIFO space

   sensor_reg_table u_table (
      .index (idx),
      .entry (entry)
   );

   assign push_cmd = {SCCB_DEV_ADDR, entry};
   assign push     = push_req && !full;      // Back-pressure holds the index

   always_ff @(posedge clock_20k or negedge camera_rstn) begin
      if (!camera_rstn) begin
         state        <= INIT_PUSH;
         idx          <= '0;
         push_req     <= 1'b0;
         config_done  <= 1'b0;
         strobe_flash <= 1'b0;
      end else if (!init_en) begin           // Synchronous restart
         state        <= INIT_PUSH;
         idx          <= '0;
         push_req     <= 1'b0;
         config_done  <= 1'b0;
         strobe_flash <= 1'b0;
      end else begin
         case (state)
            INIT_PUSH: begin
               if (!push_req) begin
                  push_req <= 1'b1;          // Arm on the first enabled cycle
               end else if (push) begin
                  if (idx == tbl_index_t'(INIT_COUNT - 1)) begin
                     push_req <= 1'b0;       // Last init entry taken
                     state    <= INIT_DRAIN;
                  end else begin
                     idx <= idx + 1'b1;      // One entry per cycle
                  end
               end
            end

            INIT_DRAIN: begin
               // Done only when the last STOP has gone out
               if (empty && !busy) begin
                  config_done <= 1'b1;
                  state       <= READY;
               end
            end

            READY: begin
               if (press_evt) begin
                  idx          <= STROBE_ON_IDX;
                  strobe_flash <= 1'b1;
                  push_req     <= 1'b1;
                  state        <= STROBE_PUSH;
               end else if (release_evt) begin
                  idx          <= STROBE_OFF_IDX;
                  strobe_flash <= 1'b0;
                  push_req     <= 1'b1;
                  state        <= STROBE_PUSH;
               end
            end

            STROBE_PUSH: begin
               // Key events are ignored until this push lands
               if (push) begin
                  push_req <= 1'b0;
                  state    <= READY;
               end
            end

            default: state <= INIT_PUSH;
         endcase
      end
   end

endmodule

/* hw/cmd_fifo.sv */
// Command FIFO, holds pending SCCB writes between sequencer and bus writer
`timescale 1ns/1ps

module cmd_fifo #(
   parameter int FIFO_DEPTH = 4              // Power of two
) (
   input  logic                      clock_20k,
   input  logic                      camera_rstn,
   input  logic                      push,
   input  logic                      pop,
   input  camera_cfg_pkg::sccb_cmd_t push_cmd,
   output camera_cfg_pkg::sccb_cmd_t head_cmd,
   output logic                      full,
   output logic                      empty
);

   import camera_cfg_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);

   sccb_cmd_t  mem [FIFO_DEPTH];             // Command storage
   logic [AW:0] wr_ptr;                      // Extra MSB tells full from empty
   logic [AW:0] rd_ptr;
   logic        do_push;
   logic        do_pop;

   assign do_push = push && !full;           // Guard against overrun
   assign do_pop  = pop && !empty;

   always_ff @(posedge clock_20k) begin
      if (do_push)
         mem[wr_ptr[AW-1:0]] <= push_cmd;
   end

   always_ff @(posedge clock_20k or negedge camera_rstn) begin
      if (!camera_rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Oldest entry shown straight from storage
   assign head_cmd = mem[rd_ptr[AW-1:0]];

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);   // Wrapped once

endmodule

/* hw/sccb_writer.sv */
// SCCB bus writer, sends one four-byte command with START, acknowledge slots and STOP
`timescale 1ns/1ps

module sccb_writer (
   input  logic                      clock_20k,
   input  logic                      camera_rstn,
   input  logic                      empty,
   input  camera_cfg_pkg::sccb_cmd_t head_cmd,
   output logic                      pop,
   output logic                      busy,
   output logic                      sccb_nack,
   output logic                      i2c_sclk,
   inout  wire                       i2c_sdat
);

   import camera_cfg_pkg::*;

   wr_state_t state;
   sccb_cmd_t shift_q;                       // MSB is the bit on the wire
   logic [2:0] bit_cnt;                      // Bits left in byte, phase in STOP
   logic [1:0] byte_cnt;                     // Byte 0 is device address
   logic       scl_q;
   logic       sda_rel;                      // 1 releases SDA to the pull-up

   assign pop      = (state == IDLE) && !empty;    // Take head and start in one edge
   assign i2c_sclk = scl_q;
   assign i2c_sdat = sda_rel ? 1'bz : 1'b0;        // Open drain

   always_ff @(posedge clock_20k) begin
      if (pop)
         shift_q <= head_cmd;
      else if (state == BIT_HIGH)
         shift_q <= {shift_q[30:0], 1'b0};         // Next bit up front
   end

   always_ff @(posedge clock_20k or negedge camera_rstn) begin
      if (!camera_rstn) begin
         state     <= IDLE;
         bit_cnt   <= '0;
         byte_cnt  <= '0;
         scl_q     <= 1'b1;
         sda_rel   <= 1'b1;
         busy      <= 1'b0;
         sccb_nack <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (pop) begin
                  sda_rel  <= 1'b0;          // START, SDA falls under high SCL
                  busy     <= 1'b1;
                  byte_cnt <= '0;
                  state    <= START;
               end
            end

            START: begin
               scl_q   <= 1'b0;
               sda_rel <= shift_q[31];       // First bit with SCL low
               bit_cnt <= 3'd7;
               state   <= BIT_LOW;
            end

            BIT_LOW: begin
               scl_q <= 1'b1;
               state <= BIT_HIGH;
            end

            BIT_HIGH: begin
               scl_q <= 1'b0;
               if (bit_cnt == 3'd0) begin
                  sda_rel <= 1'b1;           // Hand SDA to the slave
                  state   <= ACK_LOW;
               end else begin
                  sda_rel <= shift_q[30];    // Bit after the one just sent
                  bit_cnt <= bit_cnt - 1'b1;
                  state   <= BIT_LOW;
               end
            end

            ACK_LOW: begin
               scl_q <= 1'b1;
               state <= ACK_HIGH;
            end

            ACK_HIGH: begin
               if (i2c_sdat)
                  sccb_nack <= 1'b1;         // Sticky, write still completes
               scl_q <= 1'b0;
               if (byte_cnt == 2'd3) begin
                  sda_rel <= 1'b0;           // Hold SDA low ahead of STOP
                  bit_cnt <= 3'd0;
                  state   <= STOP;
               end else begin
                  byte_cnt <= byte_cnt + 1'b1;
                  sda_rel  <= shift_q[31];   // MSB of next byte
                  bit_cnt  <= 3'd7;
                  state    <= BIT_LOW;
               end
            end

            STOP: begin
               if (bit_cnt == 3'd0) begin
                  scl_q   <= 1'b1;           // SCL up first
                  bit_cnt <= 3'd1;
               end else begin
                  sda_rel <= 1'b1;           // SDA rises, bus free
                  busy    <= 1'b0;
                  state   <= IDLE;
               end
            end

            default: state <= IDLE;
         endcase
      end
   end

endmodule

/* hw/camera_config_top.sv */
// Camera config top, links key debounce, sequencer, command FIFO and SCCB writer
`timescale 1ns/1ps

module camera_config_top #(
   parameter int FIFO_DEPTH     = 4,
   parameter int DEBOUNCE_TICKS = 200
) (
   input  logic clock_20k,
   input  logic camera_rstn,
   input  logic init_en,
   input  logic key,
   output logic config_done,
   output logic strobe_flash,
   output logic sccb_nack,
   output logic i2c_sclk,
   inout  wire  i2c_sdat
);

   import camera_cfg_pkg::*;

   logic      press_evt;
   logic      release_evt;
   logic      push;                          // Sequencer to FIFO
   logic      pop;                           // Writer takes head
   logic      full;
   logic      empty;
   logic      busy;                          // Writer mid-transfer
   sccb_cmd_t push_cmd;
   sccb_cmd_t head_cmd;

   key_debounce #(
      .DEBOUNCE_TICKS (DEBOUNCE_TICKS)
   ) u_debounce (
      .clock_20k   (clock_20k),
      .camera_rstn (camera_rstn),
      .key         (key),
      .press_evt   (press_evt),
      .release_evt (release_evt)
   );

   config_sequencer u_seq (
      .clock_20k    (clock_20k),
      .camera_rstn  (camera_rstn),
      .init_en      (init_en),
      .press_evt    (press_evt),
      .release_evt  (release_evt),
      .full         (full),
      .empty        (empty),
      .busy         (busy),
      .push         (push),
      .push_cmd     (push_cmd),
      .config_done  (config_done),
      .strobe_flash (strobe_flash)
   );

   cmd_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clock_20k   (clock_20k),
      .camera_rstn (camera_rstn),
      .push        (push),
      .pop         (pop),
      .push_cmd    (push_cmd),
      .head_cmd    (head_cmd),
      .full        (full),
      .empty       (empty)
   );

   sccb_writer u_writer (
      .clock_20k   (clock_20k),
      .camera_rstn (camera_rstn),
      .empty       (empty),
      .head_cmd    (head_cmd),
      .pop         (pop),
      .busy        (busy),
      .sccb_nack   (sccb_nack),
      .i2c_sclk    (i2c_sclk),
      .i2c_sdat    (i2c_sdat)
   );

endmodule

/* sim/sccb_properties.sv */
// SCCB writer assertions on FIFO pop, SDA timing against SCL and busy coverage
`timescale 1ns/1ps

module sccb_properties (
   input logic                      clock_20k,
   input logic                      camera_rstn,
   input logic                      empty,
   input logic                      pop,
   input logic                      busy,
   input logic                      i2c_sclk,
   input logic                      i2c_sdat,
   input camera_cfg_pkg::wr_state_t state
);

   import camera_cfg_pkg::*;

   int assert_fails = 0;                     // Failed assertion count

   // Pop only with data waiting, a single pulse, busy from the next cycle
   pop_takes_head: assert property (@(posedge clock_20k) disable iff (!camera_rstn)
      pop |-> (!empty && !busy) ##1 (busy && !pop))
      else begin
         assert_fails++;
         $error("pop raised on an empty FIFO or not followed by one busy transfer");
      end

   // SCL high over a whole cycle, SDA may move only for START or STOP
   sda_stable_scl_high: assert property (@(posedge clock_20k) disable iff (!camera_rstn)
      (i2c_sclk && $past(i2c_sclk) && $changed(i2c_sdat)) |-> ($past(state) inside {IDLE, STOP}))
      else begin
         assert_fails++;
         $error("SDA changed while SCL was high outside START and STOP");
      end

   // Every SCL low phase and rising edge falls inside a transfer
   busy_covers_scl: assert property (@(posedge clock_20k) disable iff (!camera_rstn)
      (!i2c_sclk || $rose(i2c_sclk)) |-> busy)
      else begin
         assert_fails++;
         $error("SCL pulse seen while busy is low");
      end

endmodule

bind sccb_writer sccb_properties u_props (
   .clock_20k   (clock_20k),
   .camera_rstn (camera_rstn),
   .empty       (empty),
   .pop         (pop),
   .busy        (busy),
   .i2c_sclk    (i2c_sclk),
   .i2c_sdat    (i2c_sdat),
   .state       (state)
);

/* sim/tb_camera_config.sv */
// Testbench for the camera config loader with an SCCB slave model and a write checker
`timescale 1ns/1ps

module tb_camera_config;

   import camera_cfg_pkg::*;

   localparam int DEBOUNCE_TICKS = 8;
   localparam int TIMEOUT_CYCLES = 3 * (20 * 90 + 4 * DEBOUNCE_TICKS);
   localparam logic [7:0] DEV_ADDR = 8'h78;  // Sensor write address

   // Own copy of the sensor table, index order
   localparam reg_entry_t REF_TABLE [0:19] = '{
      24'h310311, 24'h300882, 24'h300842, 24'h310303, 24'h3017ff,
      24'h3018ff, 24'h30341a, 24'h303713, 24'h310801, 24'h363036,
      24'h36310e, 24'h3632e2, 24'h363312, 24'h3621e0, 24'h3704a0,
      24'h37035a, 24'h301602, 24'h3b070a, 24'h3b0083, 24'h3b0000
   };

   logic      clock_20k;
   logic      camera_rstn;
   logic      init_en;
   logic      key;                           // Low when pressed
   logic      config_done;
   logic      strobe_flash;
   logic      sccb_nack;
   logic      i2c_sclk;
   wire       i2c_sdat;

   logic      ack_drive;                     // Slave pulls SDA low
   logic      nack_mode;                     // Slave skips the ack of byte 1
   logic      prev_scl;
   logic      prev_sda;
   logic      in_ack;                        // Inside an ack slot
   int        rx_bits;                       // Data bits since START
   int        byte_bits;
   int        rx_byte;
   sccb_cmd_t rx_word;                       // Shift register, MSB first
   sccb_cmd_t got_cmd;
   sccb_cmd_t got_q [$];                     // Decoded writes in bus order
   sccb_cmd_t exp_q [$];                     // Expected writes
   int        writes_seen;
   int        expected_total;
   int        cycles;
   int        cmd_errors;
   int        flag_errors;
   int        other_errors;
   int        len;
   int        quiet_writes;
   integer    seed;

   camera_config_top #(
      .DEBOUNCE_TICKS (DEBOUNCE_TICKS)
   ) uut (
      .clock_20k    (clock_20k),
      .camera_rstn  (camera_rstn),
      .init_en      (init_en),
      .key          (key),
      .config_done  (config_done),
      .strobe_flash (strobe_flash),
      .sccb_nack    (sccb_nack),
      .i2c_sclk     (i2c_sclk),
      .i2c_sdat     (i2c_sdat)
   );

   pullup (i2c_sdat);                        // Open drain bus
   assign i2c_sdat = ack_drive ? 1'b0 : 1'bz;

   always #2 clock_20k = ~clock_20k;         // 4 ns period

   function automatic sccb_cmd_t expected_cmd(tbl_index_t idx);
      return {DEV_ADDR, REF_TABLE[idx]};     // Device byte, then entry
   endfunction

   task automatic check_cmd(string name, sccb_cmd_t got, sccb_cmd_t exp);
      if (got !== exp) begin
         cmd_errors++;
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         flag_errors++;
         $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic report_problem(string msg);
      other_errors++;
      $display("ERROR %0t: %s", $time, msg);
   endtask

   task automatic expect_write(tbl_index_t idx);
      exp_q.push_back(expected_cmd(idx));
      expected_total++;
   endtask

   task automatic expect_init();
      for (int i = 0; i < INIT_COUNT; i++)
         expect_write(tbl_index_t'(i));
   endtask

   // Key at one level for n samples
   task automatic hold_key(logic level, int n);
      @(posedge clock_20k);
      key <= level;
      repeat (n - 1) @(posedge clock_20k);
   endtask

   task automatic wait_bus_idle();
      while (writes_seen < expected_total)
         @(posedge clock_20k);               // Watchdog ends a stuck bus
   endtask

   task automatic wait_config_done();
      do
         @(negedge clock_20k);
      while (!config_done);
      if (writes_seen != expected_total)
         report_problem($sformatf("config_done rose after %0d of %0d writes",
                                  writes_seen, expected_total));
   endtask

   // Slave model, bus sampled mid-cycle where both lines are settled
   always @(negedge clock_20k) begin
      if (!camera_rstn) begin
         ack_drive = 1'b0;
         in_ack    = 1'b0;
         rx_bits   = 0;
         byte_bits = 0;
      end else if (prev_scl && i2c_sclk && prev_sda && !i2c_sdat) begin
         rx_bits   = 0;                      // START
         byte_bits = 0;
         rx_byte   = 0;
         in_ack    = 1'b0;
      end else if (prev_scl && i2c_sclk && !prev_sda && i2c_sdat) begin
         if (rx_bits != 32)                  // STOP
            report_problem($sformatf("STOP after %0d data bits", rx_bits));
         else
            got_q.push_back(rx_word);
         writes_seen++;
      end else if (!prev_scl && i2c_sclk && !in_ack && rx_bits < 32) begin
         rx_word = {rx_word[30:0], i2c_sdat};     // Data bit on rising SCL
         rx_bits++;
         byte_bits++;
      end else if (prev_scl && !i2c_sclk) begin
         if (in_ack) begin
            in_ack    = 1'b0;                // Ack slot over, let go
            ack_drive = 1'b0;
         end else if (byte_bits == 8) begin
            in_ack    = 1'b1;
            byte_bits = 0;
            ack_drive = !(nack_mode && rx_byte == 1);
            rx_byte++;
         end
      end
      prev_scl = i2c_sclk;
      prev_sda = i2c_sdat;
   end

   // Compare process, decoded writes against the expected queue
   always @(posedge clock_20k) begin
      if (got_q.size() > 0) begin
         got_cmd = got_q.pop_front();
         if (exp_q.size() == 0)
            report_problem($sformatf("unexpected bus write %h", got_cmd));
         else
            check_cmd("sccb_cmd", got_cmd, exp_q.pop_front());
      end
   end

   always @(posedge clock_20k) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, %0d of %0d writes seen",
                  cycles, writes_seen, expected_total);
         $display("tests failed");
         $finish;
      end
   end

   initial begin
      clock_20k      = 1'b0;
      camera_rstn    = 1'b0;
      init_en        = 1'b1;
      key            = 1'b1;                 // Released
      ack_drive      = 1'b0;
      nack_mode      = 1'b0;
      prev_scl       = 1'b1;
      prev_sda       = 1'b1;
      writes_seen    = 0;
      expected_total = 0;
      cycles         = 0;
      cmd_errors     = 0;
      flag_errors    = 0;
      other_errors   = 0;
      seed           = 32'h9b7a_9894;
      repeat (8) @(posedge clock_20k);
      camera_rstn <= 1'b1;

      // Initial table load, 18 writes in order
      expect_init();
      @(negedge clock_20k);
      check_flag("config_done", config_done, 1'b0);
      wait_config_done();
      check_flag("sccb_nack", sccb_nack, 1'b0);
      check_flag("strobe_flash", strobe_flash, 1'b0);

      expect_write(STROBE_ON_IDX);           // Held press
      hold_key(1'b0, DEBOUNCE_TICKS + 4);
      wait_bus_idle();
      @(negedge clock_20k);
      check_flag("strobe_flash", strobe_flash, 1'b1);

      expect_write(STROBE_OFF_IDX);          // Held release
      hold_key(1'b1, DEBOUNCE_TICKS + 4);
      wait_bus_idle();
      @(negedge clock_20k);
      check_flag("strobe_flash", strobe_flash, 1'b0);

      // Glitch burst, every level shorter than the debounce window
      quiet_writes = writes_seen;
      repeat (6) begin
         len = 1 + int'($unsigned($random(seed)) % (DEBOUNCE_TICKS - 1));
         hold_key(1'b0, len);
         len = 1 + int'($unsigned($random(seed)) % (DEBOUNCE_TICKS - 1));
         hold_key(1'b1, len);
      end
      @(negedge clock_20k);
      if (writes_seen != quiet_writes)
         report_problem("bus write during key glitches");
      check_flag("strobe_flash", strobe_flash, 1'b0);
      expect_write(STROBE_OFF_IDX);          // Settling high fires one release
      wait_bus_idle();
      @(negedge clock_20k);
      check_flag("strobe_flash", strobe_flash, 1'b0);

      // Restart through init_en
      @(posedge clock_20k);
      init_en <= 1'b0;
      repeat (4) @(posedge clock_20k);
      @(negedge clock_20k);
      check_flag("config_done", config_done, 1'b0);
      expect_init();
      @(posedge clock_20k);
      init_en <= 1'b1;
      wait_config_done();

      nack_mode = 1'b1;                      // Byte 1 left unacknowledged
      expect_write(STROBE_ON_IDX);
      hold_key(1'b0, DEBOUNCE_TICKS + 4);
      wait_bus_idle();
      nack_mode = 1'b0;
      @(negedge clock_20k);
      check_flag("sccb_nack", sccb_nack, 1'b1);
      check_flag("strobe_flash", strobe_flash, 1'b1);
      expect_write(STROBE_OFF_IDX);
      hold_key(1'b1, DEBOUNCE_TICKS + 4);
      wait_bus_idle();
      @(negedge clock_20k);
      check_flag("sccb_nack", sccb_nack, 1'b1);   // Sticky
      check_flag("strobe_flash", strobe_flash, 1'b0);

      repeat (20) @(posedge clock_20k);
      if (exp_q.size() != 0)
         report_problem($sformatf("%0d expected writes never seen", exp_q.size()));
      $display("Errors: %0d command, %0d flag, %0d other, %0d assertion",
               cmd_errors, flag_errors, other_errors, uut.u_writer.u_props.assert_fails);
      if (cmd_errors + flag_errors + other_errors + uut.u_writer.u_props.assert_fails == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* flist.f */
hw/camera_cfg_pkg.sv
hw/sensor_reg_table.sv
hw/key_debounce.sv
hw/config_sequencer.sv
hw/cmd_fifo.sv
hw/sccb_writer.sv
hw/camera_config_top.sv
sim/sccb_properties.sv
sim/tb_camera_config.sv
